// File: Makefile
# Verilator build and run of the CLINT testbench

VERILATOR ?= verilator
TOP       ?= clint_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: axi_slave/axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave (
	input  logic                                clk,
	input  logic                                reset,

	// write address
	input  logic [clint_pkg::addr_w-1:0]        awaddr,
	input  logic                                awvalid,
	output logic                                awready,

	// write data
	input  logic [clint_pkg::data_w-1:0]        wdata,
	input  logic [clint_pkg::strb_w-1:0]        wstrb,
	input  logic                                wvalid,
	output logic                                wready,

	// write response
	output clint_pkg::axi_resp_e                bresp,
	output logic                                bvalid,
	input  logic                                bready,

	// read address
	input  logic [clint_pkg::addr_w-1:0]        araddr,
	input  logic                                arvalid,
	output logic                                arready,

	// read data
	output logic [clint_pkg::data_w-1:0]        rdata,
	output clint_pkg::axi_resp_e                rresp,
	output logic                                rvalid,
	input  logic                                rready,

	// register side
	output clint_pkg::reg_req_t                 req,
	input  clint_pkg::reg_rsp_t                 rsp
);

	logic wr_acc; // write taken this cycle
	logic rd_acc; // read taken this cycle

	// aw and w must arrive together, no response outstanding
	assign wr_acc = awvalid && wvalid && !bvalid;

	// read waits if a write is taken in the same cycle
	assign rd_acc = arvalid && !rvalid && !wr_acc;

	assign awready = wr_acc;
	assign wready  = wr_acc; // both channels handshake together
	assign arready = rd_acc;

	// single-cycle access toward the register block
	always_comb begin
		req.wr    = wr_acc;
		req.rd    = rd_acc;
		req.addr  = wr_acc ? awaddr : araddr; // write has priority on the shared port
		req.wdata = wdata;
		req.wstrb = wstrb;
	end

	// write response flag
	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
		end else if (wr_acc) begin
			bvalid <= 1'b1; // response in the next cycle
		end else if (bvalid && bready) begin
			bvalid <= 1'b0; // master took it
		end
	end

	// response code captured at accept
	always_ff @(posedge clk) begin
		if (wr_acc)
			bresp <= rsp.err ? clint_pkg::resp_slverr : clint_pkg::resp_okay;
	end

	// read data flag
	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (rd_acc) begin
			rvalid <= 1'b1;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

	// read payload, held until rready since no accept while rvalid
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			rdata <= rsp.rdata;
			rresp <= rsp.err ? clint_pkg::resp_slverr : clint_pkg::resp_okay;
		end
	end

endmodule

`default_nettype wire

// File: common/clint_pkg.sv
`default_nettype none

package clint_pkg;

	// bus widths
	parameter int addr_w = 16;
	parameter int data_w = 32;
	parameter int strb_w = data_w / 8; // one strobe per byte lane

	// standard clint offsets, single hart
	parameter logic [addr_w-1:0] off_msip        = 16'h0000;
	parameter logic [addr_w-1:0] off_mtimecmp_lo = 16'h4000;
	parameter logic [addr_w-1:0] off_mtimecmp_hi = 16'h4004;
	parameter logic [addr_w-1:0] off_mtime_lo    = 16'hBFF8;
	parameter logic [addr_w-1:0] off_mtime_hi    = 16'hBFFC;

	// decoded register
	typedef enum logic [2:0] {
		sel_none,
		sel_msip,
		sel_cmp_lo,
		sel_cmp_hi,
		sel_time_lo,
		sel_time_hi
	} reg_sel_e;

	// axi response codes, exokay/decerr unused
	typedef enum logic [1:0] {
		resp_okay   = 2'd0,
		resp_slverr = 2'd2
	} axi_resp_e;

	// one register access, slave to regs
	typedef struct packed {
		logic              wr;
		logic              rd;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic [strb_w-1:0] wstrb;
	} reg_req_t;

	// same-cycle answer, regs to slave
	typedef struct packed {
		logic [data_w-1:0] rdata;
		logic              err;   // unmapped offset
	} reg_rsp_t;

	// word load into mtime
	typedef struct packed {
		logic              lo_en;
		logic              hi_en;
		logic [data_w-1:0] data;
		logic [strb_w-1:0] wstrb;
	} time_load_t;

	// replace strobed bytes of a word
	function automatic logic [data_w-1:0] strb_merge(
		input logic [data_w-1:0] old_val,
		input logic [data_w-1:0] new_val,
		input logic [strb_w-1:0] strb
	);
		logic [data_w-1:0] res;
		int i;
		res = old_val;
		for (i = 0; i < strb_w; i++) begin
			if (strb[i])
				res[8*i +: 8] = new_val[8*i +: 8]; // lane i from the bus
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// File: hdl/clint_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clint_regs (
	input  logic                          clk,
	input  logic                          reset,
	input  clint_pkg::reg_req_t           req,
	output clint_pkg::reg_rsp_t           rsp,
	input  logic [2*clint_pkg::data_w-1:0] mtime,
	output logic [2*clint_pkg::data_w-1:0] mtimecmp,
	output clint_pkg::time_load_t         load,
	output logic                          msip
);

	clint_pkg::reg_sel_e sel;

	logic [clint_pkg::data_w-1:0] cmp_lo; // mtimecmp low word
	logic [clint_pkg::data_w-1:0] cmp_hi; // mtimecmp high word

	// offset decode
	always_comb begin
		case (req.addr)
			clint_pkg::off_msip:        sel = clint_pkg::sel_msip;
			clint_pkg::off_mtimecmp_lo: sel = clint_pkg::sel_cmp_lo;
			clint_pkg::off_mtimecmp_hi: sel = clint_pkg::sel_cmp_hi;
			clint_pkg::off_mtime_lo:    sel = clint_pkg::sel_time_lo;
			clint_pkg::off_mtime_hi:    sel = clint_pkg::sel_time_hi;
			default:                    sel = clint_pkg::sel_none;
		endcase
	end

	// software interrupt, only bit 0 kept
	always_ff @(posedge clk) begin
		if (reset) begin
			msip <= 1'b0;
		end else if (req.wr && sel == clint_pkg::sel_msip && req.wstrb[0]) begin
			msip <= req.wdata[0];
		end
	end

	// compare register, all ones keeps mtip low
	always_ff @(posedge clk) begin
		if (reset) begin
			cmp_lo <= '1;
			cmp_hi <= '1;
		end else if (req.wr) begin
			if (sel == clint_pkg::sel_cmp_lo)
				cmp_lo <= clint_pkg::strb_merge(cmp_lo, req.wdata, req.wstrb);
			if (sel == clint_pkg::sel_cmp_hi)
				cmp_hi <= clint_pkg::strb_merge(cmp_hi, req.wdata, req.wstrb);
		end
	end

	assign mtimecmp = {cmp_hi, cmp_lo};

	// mtime lives in the timer, pass writes on as loads
	always_comb begin
		load.lo_en = req.wr && (sel == clint_pkg::sel_time_lo);
		load.hi_en = req.wr && (sel == clint_pkg::sel_time_hi);
		load.data  = req.wdata;
		load.wstrb = req.wstrb; // merge done in the timer
	end

	// read mux
	always_comb begin
		case (sel)
			clint_pkg::sel_msip:
				rsp.rdata = {{(clint_pkg::data_w-1){1'b0}}, msip}; // upper bits zero
			clint_pkg::sel_cmp_lo:
				rsp.rdata = cmp_lo;
			clint_pkg::sel_cmp_hi:
				rsp.rdata = cmp_hi;
			clint_pkg::sel_time_lo:
				rsp.rdata = mtime[clint_pkg::data_w-1:0];
			clint_pkg::sel_time_hi:
				rsp.rdata = mtime[2*clint_pkg::data_w-1:clint_pkg::data_w];
			default:
				rsp.rdata = '0; // unmapped reads zero
		endcase
		rsp.err = (req.wr || req.rd) && (sel == clint_pkg::sel_none);
	end

endmodule

`default_nettype wire

// File: hdl/clint_top.sv
`timescale 1ns/1ps
`default_nettype none

module clint_top #(
	parameter int TICK_DIV = 1 // clocks per mtime increment
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [clint_pkg::addr_w-1:0] awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [clint_pkg::data_w-1:0] wdata,
	input  logic [clint_pkg::strb_w-1:0] wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output clint_pkg::axi_resp_e         bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [clint_pkg::addr_w-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [clint_pkg::data_w-1:0] rdata,
	output clint_pkg::axi_resp_e         rresp,
	output logic                         rvalid,
	input  logic                         rready,
	output logic                         mtip,
	output logic                         msip
);

	clint_pkg::reg_req_t            req;      // slave to regs, accept cycle only
	clint_pkg::reg_rsp_t            rsp;
	clint_pkg::time_load_t          load;     // mtime word writes
	logic [2*clint_pkg::data_w-1:0] mtime;
	logic [2*clint_pkg::data_w-1:0] mtimecmp;

	axil_slave i_slave (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.req(req), .rsp(rsp)
	);

	clint_regs i_regs (
		.clk(clk), .reset(reset), .req(req), .rsp(rsp),
		.mtime(mtime), .mtimecmp(mtimecmp), .load(load), .msip(msip)
	);

	mtime_timer #(.TICK_DIV(TICK_DIV)) i_timer (
		.clk(clk), .reset(reset), .load(load),
		.mtimecmp(mtimecmp), .mtime(mtime), .mtip(mtip)
	);

endmodule

`default_nettype wire

// File: hdl/mtime_timer.sv
`timescale 1ns/1ps
`default_nettype none

module mtime_timer #(
	parameter int TICK_DIV = 1
) (
	input  logic                           clk,
	input  logic                           reset,
	input  clint_pkg::time_load_t          load,
	input  logic [2*clint_pkg::data_w-1:0] mtimecmp,
	output logic [2*clint_pkg::data_w-1:0] mtime,
	output logic                           mtip
);

	// prescaler width, at least one bit
	localparam int pw = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [pw-1:0] presc_max = pw'(TICK_DIV - 1);

	logic [pw-1:0]                presc;
	logic                         tick;     // mtime advances this cycle
	logic [clint_pkg::data_w-1:0] mtime_lo;
	logic [clint_pkg::data_w-1:0] mtime_hi;
	logic [clint_pkg::data_w:0]   lo_inc;   // low word plus carry out

	assign tick   = (presc == presc_max);
	assign lo_inc = {1'b0, mtime_lo} + 1'b1;

	// prescaler, restarts on any load
	always_ff @(posedge clk) begin
		if (reset) begin
			presc <= '0;
		end else if (load.lo_en || load.hi_en) begin
			presc <= '0;
		end else if (tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	// counter, a load wins over the increment
	always_ff @(posedge clk) begin
		if (reset) begin
			mtime_lo <= '0;
			mtime_hi <= '0;
		end else if (load.lo_en) begin
			mtime_lo <= clint_pkg::strb_merge(mtime_lo, load.data, load.wstrb);
		end else if (load.hi_en) begin
			mtime_hi <= clint_pkg::strb_merge(mtime_hi, load.data, load.wstrb);
		end else if (tick) begin
			mtime_lo <= lo_inc[clint_pkg::data_w-1:0];
			mtime_hi <= mtime_hi + lo_inc[clint_pkg::data_w]; // carry into high word
		end
	end

	assign mtime = {mtime_hi, mtime_lo};

	// timer interrupt, unsigned compare, one cycle behind
	always_ff @(posedge clk) begin
		if (reset)
			mtip <= 1'b0;
		else
			mtip <= (mtime >= mtimecmp);
	end

endmodule

`default_nettype wire

// File: tb.f
common/clint_pkg.sv
axi_slave/axil_slave.sv
hdl/clint_regs.sv
hdl/mtime_timer.sv
hdl/clint_top.sv
test/clint_properties.sv
test/clint_tb.sv

// File: test/clint_properties.sv
`timescale 1ns/1ps
`default_nettype none

module clint_properties (
	input logic        clk,
	input logic        reset,
	input logic        awready,
	input logic [1:0]  bresp,
	input logic        bvalid,
	input logic        bready,
	input logic [31:0] rdata,
	input logic [1:0]  rresp,
	input logic        rvalid,
	input logic        rready,
	input logic        mtip
);

	// write response held until bready
	b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid or bresp changed before bready");

	// read data held until rready
	r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));
		else $error("rvalid, rdata or rresp changed before rready");

	// no new write while a response waits
	aw_blocked: assert property (@(posedge clk) disable iff (reset)
		bvalid |-> !awready)
		else $error("awready high with bvalid pending");

	// first compare after release sees mtime 0 against the reset mtimecmp
	mtip_reset: assert property (@(posedge clk) $fell(reset) |=> !mtip)
		else $error("mtip high in the cycle after reset"); // cmp resets to all ones

endmodule

// top ports are the slave and timer nets
bind clint_top clint_properties i_props (
	.clk(clk), .reset(reset), .awready(awready),
	.bresp(bresp), .bvalid(bvalid), .bready(bready),
	.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
	.mtip(mtip)
);

`default_nettype wire

// File: test/clint_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clint_tb;

	localparam int tick_div = 4; // clocks per mtime step in this run

	typedef enum logic [2:0] {
		op_wr,    // write, check bresp
		op_rd,    // read, check data and rresp
		op_rng,   // read, data within [exp, bound]
		op_delta, // read, change since previous read within elapsed ticks
		op_pin    // wait for mtip (data 0) or msip (data 1) to reach exp
	} op_e;

	logic clk;
	logic reset;
	logic [15:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	clint_pkg::axi_resp_e bresp;
	logic bvalid;
	logic bready;
	logic [15:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	clint_pkg::axi_resp_e rresp;
	logic rvalid;
	logic rready;
	logic mtip;
	logic msip;

	// stimulus table, one column per queue
	string t_name[$];
	op_e t_op[$];
	logic [15:0] t_addr[$];
	logic [31:0] t_data[$];
	logic [3:0] t_strb[$];
	logic [31:0] t_exp[$];
	logic [31:0] t_bound[$];
	logic [1:0] t_resp[$];
	int t_gap[$]; // idle cycles before the step

	integer seed = 32'h957b;
	int cyc = 0;
	int n_checks = 0;
	int n_errors = 0;
	logic table_ready = 1'b0;

	clint_top #(.TICK_DIV(tick_div)) i_dut (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.mtip(mtip), .msip(msip)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	always @(posedge clk) cyc <= cyc + 1; // cycle stamp for timing checks

	task automatic add_step(input string name, input op_e op, input logic [15:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input logic [31:0] exp,
			input logic [31:0] bound, input logic [1:0] resp, input int gap);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_strb.push_back(strb);
		t_exp.push_back(exp);
		t_bound.push_back(bound);
		t_resp.push_back(resp);
		t_gap.push_back(gap);
	endtask

	// expected word after a strobed write
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	// 0 to 3 cycles of ready held low
	task automatic hold_ready_low();
		integer r;
		int dly;
		r = $random(seed);
		dly = r & 3;
		repeat (dly) begin
			@(posedge clk);
			#5;
		end
	endtask

	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		#5;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1; // aw and w offered together
		wvalid = 1'b1;
		@(negedge clk);
		while (!awready) @(negedge clk);
		n_checks++;
		if (wready !== 1'b1) begin
			$display("wready was not high together with awready at %0t", $time);
			n_errors++;
		end
		@(posedge clk); // accept edge
		#5;
		awvalid = 1'b0;
		wvalid = 1'b0;
		hold_ready_low();
		bready = 1'b1;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		resp = bresp;
		@(posedge clk);
		#5;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
			output logic [1:0] resp, output int acc_cyc);
		@(posedge clk);
		#5;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		acc_cyc = cyc; // data sampled at the coming edge
		@(posedge clk);
		#5;
		arvalid = 1'b0;
		hold_ready_low();
		rready = 1'b1;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#5;
		rready = 1'b0;
	endtask

	task automatic check_pin(input string name, input logic use_msip, input logic exp,
			input int bound);
		logic val;
		int waited;
		waited = 0;
		@(negedge clk);
		val = use_msip ? msip : mtip;
		while (val !== exp && waited < bound) begin
			@(negedge clk);
			waited++;
			val = use_msip ? msip : mtip;
		end
		n_checks++;
		if (val !== exp) begin
			$display("ERROR %s: expected %0d, actual %0d after %0d cycles",
				name, exp, val, waited);
			n_errors++;
		end
	endtask

	task automatic build_table();
		logic [31:0] ones;
		ones = 32'hFFFF_FFFF;
		// after reset
		add_step("rst_mtip", op_pin, 16'h0, 32'd0, 4'h0, 32'd0, 32'd0, 2'd0, 0);
		add_step("rst_msip_pin", op_pin, 16'h0, 32'd1, 4'h0, 32'd0, 32'd0, 2'd0, 0);
		add_step("rst_msip_rd", op_rd, clint_pkg::off_msip, 32'd0, 4'h0, 32'd0, 32'd0, 2'd0, 0);
		add_step("rst_cmp_lo", op_rd, clint_pkg::off_mtimecmp_lo, 32'd0, 4'h0, ones, 32'd0, 2'd0, 0);
		add_step("rst_cmp_hi", op_rd, clint_pkg::off_mtimecmp_hi, 32'd0, 4'h0, ones, 32'd0, 2'd0, 0);
		// mtimecmp round trip, full then partial strobes
		add_step("cmp_lo_wr", op_wr, clint_pkg::off_mtimecmp_lo, 32'h1122_3344, 4'hF, 32'd0,
			32'd0, 2'd0, 0);
		add_step("cmp_hi_wr", op_wr, clint_pkg::off_mtimecmp_hi, 32'h5566_7788, 4'hF, 32'd0,
			32'd0, 2'd0, 1);
		add_step("cmp_lo_rd", op_rd, clint_pkg::off_mtimecmp_lo, 32'd0, 4'h0, 32'h1122_3344,
			32'd0, 2'd0, 0);
		add_step("cmp_hi_rd", op_rd, clint_pkg::off_mtimecmp_hi, 32'd0, 4'h0, 32'h5566_7788,
			32'd0, 2'd0, 0);
		add_step("cmp_lo_part", op_wr, clint_pkg::off_mtimecmp_lo, 32'hAABB_CCDD, 4'b0101,
			32'd0, 32'd0, 2'd0, 0);
		add_step("cmp_lo_part_rd", op_rd, clint_pkg::off_mtimecmp_lo, 32'd0, 4'h0,
			merge_bytes(32'h1122_3344, 32'hAABB_CCDD, 4'b0101), 32'd0, 2'd0, 0);
		add_step("cmp_hi_part", op_wr, clint_pkg::off_mtimecmp_hi, 32'h99AA_BBCC, 4'b1000,
			32'd0, 32'd0, 2'd0, 0);
		add_step("cmp_hi_part_rd", op_rd, clint_pkg::off_mtimecmp_hi, 32'd0, 4'h0,
			merge_bytes(32'h5566_7788, 32'h99AA_BBCC, 4'b1000), 32'd0, 2'd0, 2);
		add_step("cmp_hi_ones", op_wr, clint_pkg::off_mtimecmp_hi, ones, 4'hF, 32'd0, 32'd0,
			2'd0, 0);
		// msip, upper bits of the write are dropped
		add_step("msip_set", op_wr, clint_pkg::off_msip, ones, 4'hF, 32'd0, 32'd0, 2'd0, 0);
		add_step("msip_pin_set", op_pin, 16'h0, 32'd1, 4'h0, 32'd1, 32'd0, 2'd0, 0);
		add_step("msip_rd_set", op_rd, clint_pkg::off_msip, 32'd0, 4'h0, 32'd1, 32'd0, 2'd0, 0);
		add_step("msip_clr", op_wr, clint_pkg::off_msip, 32'd0, 4'hF, 32'd0, 32'd0, 2'd0, 0);
		add_step("msip_pin_clr", op_pin, 16'h0, 32'd1, 4'h0, 32'd0, 32'd0, 2'd0, 0);
		add_step("msip_rd_clr", op_rd, clint_pkg::off_msip, 32'd0, 4'h0, 32'd0, 32'd0, 2'd0, 1);
		// mtime loads, lo close to wrapping into hi
		add_step("time_hi_ld", op_wr, clint_pkg::off_mtime_hi, 32'd5, 4'hF, 32'd0, 32'd0, 2'd0, 0);
		add_step("time_lo_ld", op_wr, clint_pkg::off_mtime_lo, 32'hFFFF_FFF0, 4'hF, 32'd0,
			32'd0, 2'd0, 0);
		add_step("time_hi_rng", op_rng, clint_pkg::off_mtime_hi, 32'd0, 4'h0, 32'd5, 32'd6,
			2'd0, 0);
		add_step("time_lo_rng", op_rng, clint_pkg::off_mtime_lo, 32'd0, 4'h0, 32'hFFFF_FFF0,
			ones, 2'd0, 0);
		add_step("time_lo_delta", op_delta, clint_pkg::off_mtime_lo, 32'd0, 4'h0, 32'd0, 32'd2,
			2'd0, 12); // bound holds the margin in ticks
		// timer interrupt, cmp 0x40 ticks ahead of the load
		add_step("irq_time_hi", op_wr, clint_pkg::off_mtime_hi, 32'd0, 4'hF, 32'd0, 32'd0, 2'd0, 0);
		add_step("irq_time_lo", op_wr, clint_pkg::off_mtime_lo, 32'h100, 4'hF, 32'd0, 32'd0,
			2'd0, 0);
		add_step("irq_cmp_lo", op_wr, clint_pkg::off_mtimecmp_lo, 32'h140, 4'hF, 32'd0, 32'd0,
			2'd0, 0);
		add_step("irq_cmp_hi", op_wr, clint_pkg::off_mtimecmp_hi, 32'd0, 4'hF, 32'd0, 32'd0,
			2'd0, 0);
		add_step("irq_not_yet", op_pin, 16'h0, 32'd0, 4'h0, 32'd0, 32'd0, 2'd0, 0);
		add_step("irq_rise", op_pin, 16'h0, 32'd0, 4'h0, 32'd1, 32'((32'h40 + 8) * tick_div),
			2'd0, 0);
		add_step("irq_clear", op_wr, clint_pkg::off_mtimecmp_hi, ones, 4'hF, 32'd0, 32'd0,
			2'd0, 0);
		add_step("irq_fall", op_pin, 16'h0, 32'd0, 4'h0, 32'd0, 32'd3, 2'd0, 0);
		// unmapped offset
		add_step("bad_wr", op_wr, 16'h1000, 32'hDEAD_BEEF, 4'hF, 32'd0, 32'd0,
			clint_pkg::resp_slverr, 0);
		add_step("bad_rd", op_rd, 16'h1000, 32'd0, 4'h0, 32'd0, 32'd0, clint_pkg::resp_slverr, 0);
		add_step("bad_cmp_lo", op_rd, clint_pkg::off_mtimecmp_lo, 32'd0, 4'h0, 32'h140, 32'd0,
			2'd0, 0);
		add_step("bad_cmp_hi", op_rd, clint_pkg::off_mtimecmp_hi, 32'd0, 4'h0, ones, 32'd0,
			2'd0, 0);
		add_step("bad_msip_pin", op_pin, 16'h0, 32'd1, 4'h0, 32'd0, 32'd0, 2'd0, 0);
	endtask

	// watchdog, 50 cycles per table step
	initial begin
		wait (table_ready);
		repeat (t_name.size() * 50) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", t_name.size() * 50);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [31:0] val;
		logic [31:0] last_val;
		logic [31:0] delta;
		logic [31:0] max_delta;
		logic [1:0] resp;
		int acc_cyc;
		int last_cyc;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		last_val = '0;
		last_cyc = 0;
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		#5;
		reset = 1'b0;

		for (int i = 0; i < t_name.size(); i++) begin
			repeat (t_gap[i]) @(posedge clk);
			case (t_op[i])
				op_wr: begin
					axi_write(t_addr[i], t_data[i], t_strb[i], resp);
					n_checks++;
					if (resp !== t_resp[i]) begin
						$display("ERROR %s: expected bresp %0d, actual %0d", t_name[i], t_resp[i], resp);
						n_errors++;
					end
				end
				op_pin: check_pin(t_name[i], t_data[i][0], t_exp[i][0], int'(t_bound[i]));
				default: begin // the three read kinds
					axi_read(t_addr[i], val, resp, acc_cyc);
					n_checks++;
					if (resp !== t_resp[i]) begin
						$display("ERROR %s: expected rresp %0d, actual %0d", t_name[i], t_resp[i], resp);
						n_errors++;
					end
					n_checks++;
					if (t_op[i] == op_rd && val !== t_exp[i]) begin
						$display("ERROR %s: expected %h, actual %h", t_name[i], t_exp[i], val);
						n_errors++;
					end
					if (t_op[i] == op_rng && (val < t_exp[i] || val > t_bound[i])) begin
						$display("ERROR %s: expected %h..%h, actual %h", t_name[i], t_exp[i],
							t_bound[i], val);
						n_errors++;
					end
					delta = val - last_val; // wraps like the counter
					max_delta = 32'((acc_cyc - last_cyc) / tick_div) + t_bound[i];
					if (t_op[i] == op_delta && (delta == 0 || delta > max_delta)) begin
						$display("ERROR %s: expected step 1..%0d, actual %0d", t_name[i],
							max_delta, delta);
						n_errors++;
					end
					last_val = val;
					last_cyc = acc_cyc;
				end
			endcase
		end

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
